// File: rtl/alu_ctrl_pkg.sv
package alu_ctrl_pkg;

    // per-slice control word, top bit first
    typedef struct packed {
        logic       carry_in;      // carry into bit 0, also the shift-in bit for RSHFT
        logic       b_inv;         // invert the second operand before the cell logic
        logic       carry_disable; // masks the carry so the cell computes a pure logic function
        logic [1:0] mux_sel;       // 0 sum, 1 and, 2 or, 3 direct bit from the left neighbour
    } slice_ctrl_t;

    // each command is laid out so that its bits are the raw slice control
    typedef enum logic [4:0] {
        ADD   = 5'b00000,
        SUB   = 5'b11000, // a + ~b + 1, carry out set means no borrow
        XOR   = 5'b00100,
        XNOR  = 5'b01100, // also NOT when a is zero
        COMP  = 5'b01000, // a + ~b, carry out set means a > b for unequal operands
        AND   = 5'b00101,
        OR    = 5'b00110,
        RSHFT = 5'b00111  // b moves right by one, a is ignored
    } alu_cmd_e;

    // a command can be read back as the control word without any decoding
    typedef union packed {
        alu_cmd_e    cmd;
        slice_ctrl_t ctrl;
    } alu_ctrl_u;

endpackage

// File: rtl/alu_data_pkg.sv
package alu_data_pkg;

    // operand width handled by one lookahead slice
    localparam int SLICE_BITS = 4;

    typedef logic [SLICE_BITS-1:0] nibble_t;

    // status flags returned with every result
    typedef struct packed {
        logic zero;     // result is all zeros
        logic negative; // top bit of the result
        logic carry;    // chain carry for arithmetic, shifted-out bit for RSHFT
        logic greater;  // a > b, meaningful for COMP on unequal operands only
    } alu_flags_t;

endpackage

// File: rtl/bit_cell.sv
`timescale 1ns/10ps

module bit_cell (
    input  logic                      a,
    input  logic                      b,
    input  logic                      carry_in,
    input  logic                      direct_in, // bit handed over by the left neighbour
    input  alu_ctrl_pkg::slice_ctrl_t ctrl,
    output logic                      res,
    output logic                      gen,
    output logic                      prop,
    output logic                      b_eff
);

    logic carry_masked;
    logic mux_out;

    assign b_eff        = b ^ ctrl.b_inv;
    assign carry_masked = carry_in & ~ctrl.carry_disable;

    assign gen  = a & b_eff;
    assign prop = a | b_eff;

    // propagate-and-not-generate is the half sum, so mux_sel 0 yields xor of a and b_eff
    always_comb begin
        case (ctrl.mux_sel)
            2'b00:   mux_out = prop & ~gen;
            2'b01:   mux_out = gen;
            2'b10:   mux_out = prop;
            default: mux_out = direct_in;
        endcase
    end

    assign res = mux_out ^ carry_masked; // full sum when the carry is enabled

endmodule

// File: rtl/alu_slice.sv
`timescale 1ns/10ps

module alu_slice (
    input  alu_data_pkg::nibble_t     a,
    input  alu_data_pkg::nibble_t     b,
    input  alu_ctrl_pkg::slice_ctrl_t ctrl,
    output alu_data_pkg::nibble_t     res,
    output logic                      carry_out
);

    localparam int N = alu_data_pkg::SLICE_BITS;

    alu_data_pkg::nibble_t gen;
    alu_data_pkg::nibble_t prop;
    logic [N:0]            carry;
    logic [N:0]            b_eff;  // top entry is the bit shifted in from above
    logic                  c_in;

    assign c_in     = ctrl.carry_in;
    assign carry[0] = c_in;
    assign b_eff[N] = c_in;

    for (genvar i = 0; i < N; i++) begin : g_cell
        bit_cell u_cell (
            .a         (a[i]),
            .b         (b[i]),
            .carry_in  (carry[i]),
            .direct_in (b_eff[i+1]),
            .ctrl      (ctrl),
            .res       (res[i]),
            .gen       (gen[i]),
            .prop      (prop[i]),
            .b_eff     (b_eff[i])
        );
    end

    // two-level lookahead, every carry is a sum of products of gen, prop and c_in
    assign carry[1] = gen[0] | (c_in & prop[0]);

    assign carry[2] = gen[1]
                    | (gen[0] & prop[1])
                    | (c_in & prop[0] & prop[1]);

    assign carry[3] = gen[2]
                    | (gen[1] & prop[2])
                    | (gen[0] & prop[1] & prop[2])
                    | (c_in & prop[0] & prop[1] & prop[2]);

    assign carry[4] = gen[3]
                    | (gen[2] & prop[3])
                    | (gen[1] & prop[2] & prop[3])
                    | (gen[0] & prop[1] & prop[2] & prop[3])
                    | (c_in & prop[0] & prop[1] & prop[2] & prop[3]);

    assign carry_out = carry[N];

endmodule

// File: rtl/alu_chain.sv
`timescale 1ns/10ps

module alu_chain #(
    parameter int SLICES = 2
) (
    input  alu_ctrl_pkg::alu_cmd_e                        cmd,
    input  logic [SLICES*alu_data_pkg::SLICE_BITS-1:0]    a,
    input  logic [SLICES*alu_data_pkg::SLICE_BITS-1:0]    b,
    input  logic                                          shift_in,
    output logic [SLICES*alu_data_pkg::SLICE_BITS-1:0]    result,
    output logic                                          carry,
    output logic                                          shift_out
);

    localparam int SB = alu_data_pkg::SLICE_BITS;

    alu_ctrl_pkg::alu_ctrl_u cmd_ctrl;
    logic [SLICES:0]         slice_carry; // entry k is the carry into slice k
    logic                    is_arith;
    logic                    is_shift;

    assign cmd_ctrl.cmd = cmd;

    assign is_arith = (cmd == alu_ctrl_pkg::ADD) || (cmd == alu_ctrl_pkg::SUB) ||
                      (cmd == alu_ctrl_pkg::COMP);
    assign is_shift = (cmd == alu_ctrl_pkg::RSHFT);

    assign slice_carry[0] = cmd_ctrl.ctrl.carry_in; // command's own carry feeds the bottom

    for (genvar k = 0; k < SLICES; k++) begin : g_slice
        alu_ctrl_pkg::slice_ctrl_t slice_ctrl;
        logic                      shift_bit;

        if (k == SLICES - 1) begin : g_top
            assign shift_bit = shift_in;
        end else begin : g_low
            assign shift_bit = b[(k+1)*SB]; // lowest b bit of the slice above
        end

        // only carry_in differs between slices
        always_comb begin
            slice_ctrl = cmd_ctrl.ctrl;
            if (is_arith) begin
                slice_ctrl.carry_in = slice_carry[k];
            end else if (is_shift) begin
                slice_ctrl.carry_in = shift_bit;
            end
        end

        alu_slice u_slice (
            .a         (a[k*SB +: SB]),
            .b         (b[k*SB +: SB]),
            .ctrl      (slice_ctrl),
            .res       (result[k*SB +: SB]),
            .carry_out (slice_carry[k+1])
        );
    end

    assign carry     = slice_carry[SLICES];
    assign shift_out = b[0]; // the bit that drops off the bottom on RSHFT

endmodule

// File: rtl/alu_flags.sv
`timescale 1ns/10ps

module alu_flags #(
    parameter int SLICES = 2
) (
    input  alu_ctrl_pkg::alu_cmd_e                     cmd,
    input  logic [SLICES*alu_data_pkg::SLICE_BITS-1:0] result,
    input  logic                                       carry,
    output alu_data_pkg::alu_flags_t                   flags,
    input  logic                                       shift_out
);

    localparam int WIDTH = SLICES * alu_data_pkg::SLICE_BITS;

    typedef logic [WIDTH-1:0] word_t;

    always_comb begin
        flags          = '0;
        flags.zero     = (result == word_t'(0));
        flags.negative = result[WIDTH-1];
        case (cmd)
            alu_ctrl_pkg::ADD,
            alu_ctrl_pkg::SUB:   flags.carry = carry; // on SUB a set carry means no borrow
            alu_ctrl_pkg::COMP: begin
                flags.carry   = carry;
                flags.greater = carry;
            end
            alu_ctrl_pkg::RSHFT: flags.carry = shift_out;
            default:             flags.carry = 1'b0; // logic commands never report a carry
        endcase
    end

endmodule

// File: rtl/alu_unit.sv
`timescale 1ns/10ps

module alu_unit #(
    parameter int SLICES = 2
) (
    input  logic                                       clk,
    input  logic                                       rst,
    input  logic                                       in_valid,
    input  alu_ctrl_pkg::alu_cmd_e                     cmd,
    input  logic [SLICES*alu_data_pkg::SLICE_BITS-1:0] a,
    input  logic [SLICES*alu_data_pkg::SLICE_BITS-1:0] b,
    input  logic                                       shift_in,
    output logic                                       out_valid,
    output logic [SLICES*alu_data_pkg::SLICE_BITS-1:0] result,
    output alu_data_pkg::alu_flags_t                   flags
);

    localparam int WIDTH = SLICES * alu_data_pkg::SLICE_BITS;

    typedef logic [WIDTH-1:0] word_t;

    // result and flags are captured together
    typedef struct packed {
        word_t                    result;
        alu_data_pkg::alu_flags_t flags;
    } alu_out_t;

    word_t    chain_result;
    logic     chain_carry;
    logic     chain_shift_out;
    alu_out_t next_out;
    alu_out_t out_q;

    alu_chain #(.SLICES(SLICES)) u_chain (
        .cmd       (cmd),
        .a         (a),
        .b         (b),
        .shift_in  (shift_in),
        .result    (chain_result),
        .carry     (chain_carry),
        .shift_out (chain_shift_out)
    );

    alu_flags #(.SLICES(SLICES)) u_flags (
        .cmd       (cmd),
        .result    (chain_result),
        .carry     (chain_carry),
        .flags     (next_out.flags),
        .shift_out (chain_shift_out)
    );

    assign next_out.result = chain_result;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            out_q     <= '0;
        end else begin
            out_valid <= in_valid; // one-cycle strobe per accepted request
            if (in_valid) begin
                out_q <= next_out; // no back-pressure, a new request simply overwrites
            end
        end
    end

    assign result = out_q.result;
    assign flags  = out_q.flags;

endmodule

// File: verification/alu_unit_chk.sv
`timescale 1ns/10ps

module alu_unit_chk #(
    parameter int SLICES = 2
) (
    input logic                                       clk,
    input logic                                       rst,
    input logic                                       in_valid,
    input logic                                       out_valid,
    input logic [SLICES*alu_data_pkg::SLICE_BITS-1:0] result,
    input alu_data_pkg::alu_flags_t                   flags
);

    localparam int WIDTH = SLICES * alu_data_pkg::SLICE_BITS;

    typedef logic [WIDTH-1:0] word_t;

    // the strobe stays low through reset and on the first edge after it
    a_reset_quiet: assert property (@(posedge clk) rst |=> !out_valid)
        else $error("out_valid high during or right after reset");

    a_valid_follows: assert property (@(posedge clk) disable iff (rst) in_valid |=> out_valid)
        else $error("accepted request gave no out_valid one cycle later");

    a_no_spurious: assert property (@(posedge clk) disable iff (rst) !in_valid |=> !out_valid)
        else $error("out_valid high without a request in the cycle before");

    a_zero_flag: assert property (@(posedge clk) out_valid |-> flags.zero == (result == word_t'(0)))
        else $error("zero flag does not match the result");

endmodule

bind alu_unit alu_unit_chk #(.SLICES(SLICES)) u_chk (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .result    (result),
    .flags     (flags)
);

// File: verification/alu_unit_tb.sv
`timescale 1ns/10ps

module alu_unit_tb;

    localparam int SLICES     = 2;
    localparam int W          = SLICES * alu_data_pkg::SLICE_BITS;
    localparam int PERIOD     = 8;
    localparam int RST_CYCLES = 16;
    localparam int N_RAND     = 100;
    localparam int N_BURST    = 32;
    localparam int N_REQ      = 2 * 256 + 8 * N_RAND + 8 + N_BURST;
    // one idle cycle at most per request
    localparam int TIMEOUT    = (RST_CYCLES + 2 * N_REQ + 50) * PERIOD;

    typedef logic [W-1:0]           word_t;
    typedef alu_ctrl_pkg::alu_cmd_e cmd_t;

    typedef struct packed {
        word_t                    result;
        alu_data_pkg::alu_flags_t flags;
    } alu_exp_t;

    typedef struct packed {
        int unsigned cycle; // clock count when the request was driven
        alu_exp_t    value;
    } pending_t;

    logic                     clk = 1'b0;
    logic                     rst;
    logic                     in_valid;
    cmd_t                     cmd;
    word_t                    a;
    word_t                    b;
    logic                     shift_in;
    logic                     out_valid;
    word_t                    result;
    alu_data_pkg::alu_flags_t flags;

    pending_t    pend_q[$];
    int unsigned cycle_cnt    = 0;
    int unsigned n_sent       = 0;
    int unsigned n_recv       = 0;
    bit          idle_en      = 1'b1;
    bit          verdict_done = 1'b0;

    alu_unit #(.SLICES(SLICES)) u_dut (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .cmd       (cmd),
        .a         (a),
        .b         (b),
        .shift_in  (shift_in),
        .out_valid (out_valid),
        .result    (result),
        .flags     (flags)
    );

    always #(PERIOD / 2) clk = ~clk;

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    // expected result and flags on full-width integers
    function automatic alu_exp_t exp_alu(cmd_t c, word_t op_a, word_t op_b, logic sin);
        alu_exp_t   e;
        logic [W:0] wide;
        e = '0;
        case (c)
            alu_ctrl_pkg::ADD: begin
                wide          = {1'b0, op_a} + {1'b0, op_b};
                e.result      = wide[W-1:0];
                e.flags.carry = wide[W]; // overflow past the top bit
            end
            alu_ctrl_pkg::SUB: begin
                e.result      = op_a - op_b;
                e.flags.carry = !(op_b > op_a); // set when there is no borrow
            end
            alu_ctrl_pkg::COMP: begin
                e.result        = op_a - op_b - word_t'(1);
                e.flags.carry   = (op_a > op_b);
                e.flags.greater = (op_a > op_b);
            end
            alu_ctrl_pkg::XOR:   e.result = op_a ^ op_b;
            alu_ctrl_pkg::XNOR:  e.result = ~(op_a ^ op_b);
            alu_ctrl_pkg::AND:   e.result = op_a & op_b;
            alu_ctrl_pkg::OR:    e.result = op_a | op_b;
            default: begin
                e.result      = {sin, op_b[W-1:1]}; // RSHFT by one bit
                e.flags.carry = op_b[0];
            end
        endcase
        e.flags.zero     = (e.result == '0);
        e.flags.negative = e.result[W-1];
        return e;
    endfunction

    task automatic fail_now(input string what);
        verdict_done = 1'b1;
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_result(input word_t got, input word_t want);
        if (got !== want) begin
            fail_now($sformatf("CHECK FAILED time %0t signal result got 0x%h expected 0x%h",
                               $time, got, want));
        end
    endtask

    task automatic check_flags(input alu_data_pkg::alu_flags_t got,
                               input alu_data_pkg::alu_flags_t want);
        if (got !== want) begin
            fail_now($sformatf("CHECK FAILED time %0t signal flags (z n c g) got %b expected %b",
                               $time, got, want));
        end
    endtask

    // drives one request on the falling edge and queues what it should return
    task automatic send(input cmd_t c, input word_t op_a, input word_t op_b, input logic sin);
        pending_t p;
        @(negedge clk);
        cmd      = c;
        a        = op_a;
        b        = op_b;
        shift_in = sin;
        in_valid = 1'b1;
        p.cycle  = cycle_cnt;
        p.value  = exp_alu(c, op_a, op_b, sin);
        pend_q.push_back(p);
        n_sent++;
        if (idle_en && $urandom_range(3) == 0) begin
            @(negedge clk);
            in_valid = 1'b0;
            a        = word_t'($urandom); // inputs of an idle cycle must not matter
        end
    endtask

    always @(negedge clk) begin : compare_outputs
        pending_t p;
        if (!rst && out_valid) begin
            if (pend_q.size() == 0) begin
                fail_now("out_valid was high while no request was outstanding");
            end else begin
                p = pend_q.pop_front();
                if (cycle_cnt != p.cycle + 1) begin
                    fail_now($sformatf("a result came at cycle %0d for a request from cycle %0d",
                                       cycle_cnt, p.cycle));
                end
                check_result(result, p.value.result);
                check_flags(flags, p.value.flags);
                n_recv++;
            end
        end
    end

    initial begin : watchdog
        #(TIMEOUT);
        fail_now($sformatf("timeout with %0d of %0d results received", n_recv, n_sent));
    end

    initial begin : stimulus
        word_t ra;
        word_t rb;
        word_t top;
        cmd_t  logic_cmds [4];
        cmd_t  all_cmds [8];
        logic_cmds = '{alu_ctrl_pkg::XOR, alu_ctrl_pkg::XNOR,
                       alu_ctrl_pkg::AND, alu_ctrl_pkg::OR};
        all_cmds   = '{alu_ctrl_pkg::ADD, alu_ctrl_pkg::SUB, alu_ctrl_pkg::XOR,
                       alu_ctrl_pkg::XNOR, alu_ctrl_pkg::COMP, alu_ctrl_pkg::AND,
                       alu_ctrl_pkg::OR, alu_ctrl_pkg::RSHFT};
        void'($urandom(32'h2f20cf98));
        rst      = 1'b1;
        in_valid = 1'b0;
        cmd      = alu_ctrl_pkg::ADD;
        a        = '0;
        b        = '0;
        shift_in = 1'b0;
        top      = word_t'(1) << (W - 1);
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < 16; i++) begin // every low nibble pair, random upper bits
            for (int j = 0; j < 16; j++) begin
                ra      = word_t'($urandom);
                rb      = word_t'($urandom);
                ra[3:0] = i[3:0];
                rb[3:0] = j[3:0];
                send(alu_ctrl_pkg::ADD, ra, rb, 1'b0);
                send(alu_ctrl_pkg::SUB, ra, rb, 1'b0);
            end
        end
        for (int n = 0; n < N_RAND; n++) begin
            send(alu_ctrl_pkg::ADD, word_t'($urandom), word_t'($urandom), 1'($urandom));
            send(alu_ctrl_pkg::SUB, word_t'($urandom), word_t'($urandom), 1'($urandom));
            for (int k = 0; k < 4; k++) begin
                send(logic_cmds[k], word_t'($urandom), word_t'($urandom), 1'($urandom));
            end
            ra = word_t'($urandom);
            rb = word_t'($urandom);
            if (ra == rb) rb = ra ^ word_t'(1); // greater is undefined on equal operands
            send(alu_ctrl_pkg::COMP, ra, rb, 1'b0);
            send(alu_ctrl_pkg::RSHFT, word_t'($urandom), word_t'($urandom), 1'($urandom));
        end

        ra = word_t'($urandom);
        send(alu_ctrl_pkg::ADD, '0, '0, 1'b0);
        send(alu_ctrl_pkg::SUB, ra, ra, 1'b0);
        send(alu_ctrl_pkg::XOR, ra, ra, 1'b0);
        send(alu_ctrl_pkg::AND, ra, '0, 1'b0);
        send(alu_ctrl_pkg::ADD, '1, word_t'(1), 1'b0); // wraps to zero with a carry
        send(alu_ctrl_pkg::ADD, top - word_t'(1), word_t'(1), 1'b0);
        send(alu_ctrl_pkg::OR, top, '0, 1'b0);
        send(alu_ctrl_pkg::RSHFT, '0, '0, 1'b1);

        idle_en = 1'b0;
        for (int n = 0; n < N_BURST; n++) begin
            ra = word_t'($urandom);
            rb = word_t'($urandom);
            cmd_pick: begin
                cmd_t c;
                c = all_cmds[$urandom_range(7)];
                if (c == alu_ctrl_pkg::COMP && ra == rb) rb = ra ^ word_t'(1);
                send(c, ra, rb, 1'($urandom));
            end
        end
        idle_en = 1'b1;

        @(negedge clk);
        in_valid = 1'b0;
        repeat (2) @(negedge clk); // the last result is due one cycle after its request
        verdict_done = 1'b1;
        if (n_recv != n_sent) begin
            $display("only %0d of %0d results arrived", n_recv, n_sent);
            $display("TEST FAILED");
            $fatal(1, "results were lost");
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

    final begin
        if (!verdict_done) begin
            $display("the run ended before all checks were done");
            $display("TEST FAILED");
        end
    end

endmodule

// File: alu_unit.f
rtl/alu_ctrl_pkg.sv
rtl/alu_data_pkg.sv
rtl/bit_cell.sv
rtl/alu_slice.sv
rtl/alu_chain.sv
rtl/alu_flags.sv
rtl/alu_unit.sv
verification/alu_unit_chk.sv
verification/alu_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and looks for the pass line in the log
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module alu_unit_tb \
    -f alu_unit.f -o alu_unit_sim > build.log 2>&1 \
    && ./obj_dir/alu_unit_sim > sim.log 2>&1
grep -q "^TEST OK$" sim.log && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }
